// File: sources.f
+incdir+include
rtl/ia_loader_pkg.sv
rtl/ia_tile_sequencer.sv
rtl/ia_read_requester.sv
rtl/ia_beat_unpacker.sv
rtl/ia_lane_convert.sv
rtl/ia_tile_buffer.sv
rtl/ia_loader.sv
tests/ia_icb_mem.sv
tests/tb_ia_loader.sv

// File: tests/tb_ia_loader.sv
// testbench for the activation loader, runs two GEMM shapes against the ICB memory model
`timescale 1ns/1ps
`include "ia_loader_cfg.svh"

module tb_ia_loader;

    localparam int timeout_cycles = 20000;  // 9 tiles, each far below 2000 cycles with stalls

    typedef struct {
        int addr;
        int rows;
        int cols;
        bit first;
        bit last;
    } tile_exp_t;

    logic clk = 1'b0;
    logic rst_n;
    logic init_cfg;
    logic use_16bits;
    logic load_ia_granted;
    logic send_ia_trigger;
    logic load_ia_req;
    ia_loader_pkg::reg_word_t  k, n, m, lhs_zp, lhs_row_stride_b, lhs_base;
    logic                      icb_cmd_valid, icb_cmd_ready, icb_rsp_valid, icb_rsp_ready;
    ia_loader_pkg::addr_t      icb_cmd_addr;
    ia_loader_pkg::burst_len_t icb_cmd_len;
    ia_loader_pkg::bus_word_t  icb_rsp_rdata;
    logic ia_data_valid, ia_row_valid, ia_is_init_data, ia_calc_done, ia_sending_done;
    ia_loader_pkg::elem_t      ia_out [`IA_SIZE];

    tile_exp_t tile_q [$];      // tiles still to stream
    int        cmd_addr_q [$];  // row commands still to see
    int        cmd_len_q [$];
    int        row_cnt = 0;
    bit        done_pending = 1'b0;
    bit        req_seen = 1'b0;
    bit        grant_seen = 1'b0;
    int        req_rises = 0;
    int        cycles = 0;

    ia_loader  dut (.*);
    ia_icb_mem u_mem (.*);

    always #5 clk = ~clk;

    task automatic abort_run(string why);
        $display("%s", why);
        $display("TEST FAIL");
        $fatal(1);
    endtask

    task automatic value_error(string sig, int got, int exp);
        abort_run($sformatf("error at %0t: %s is %0d, expected %0d", $time, sig, got, exp));
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    // memory element plus zp, clamped to s16
    function automatic int expect_elem(int a);
        int raw;
        int sum;
        if (use_16bits) begin
            raw = ((((a + 1) * 7 + 3) & 255) << 8) | ((a * 7 + 3) & 255);
            if (raw > 32767) raw -= 65536;
        end else begin
            raw = (a * 7 + 3) & 255;
            if (raw > 127) raw -= 256;
        end
        sum = raw + int'(lhs_zp);
        return (sum > 32767) ? 32767 : (sum < -32768) ? -32768 : sum;
    endfunction

    // ==================================================
    // expected tile walk: band, loop pass, column tile
    // ==================================================
    task automatic plan_tiles(int kk, int nn, int mm, int base, int stride);
        int eb;
        int bands;
        int cols;
        int loops;
        tile_exp_t t;
        eb    = use_16bits ? 2 : 1;
        bands = (kk + `IA_SIZE - 1) / `IA_SIZE;
        cols  = (nn + `IA_SIZE - 1) / `IA_SIZE;
        loops = (mm + `IA_SIZE - 1) / `IA_SIZE;
        for (int b = 0; b < bands; b++) begin
            for (int l = 0; l < loops; l++) begin
                for (int c = 0; c < cols; c++) begin
                    t.addr  = base + b * `IA_SIZE * stride + c * `IA_SIZE * eb;
                    t.rows  = (b == bands - 1) ? kk - b * `IA_SIZE : `IA_SIZE;
                    t.cols  = (c == cols - 1) ? nn - c * `IA_SIZE : `IA_SIZE;
                    t.first = (c == 0);
                    t.last  = (c == cols - 1);
                    tile_q.push_back(t);
                    for (int r = 0; r < t.rows; r++) begin
                        cmd_addr_q.push_back(t.addr + r * stride);
                        cmd_len_q.push_back((t.cols * eb + 3) / 4 - 1);  // beats minus one
                    end
                end
            end
        end
    endtask

    task automatic run_gemm(bit s16, int kk, int nn, int mm, int zp, int base, int stride);
        int tiles;
        use_16bits       = s16;
        k                = kk;
        n                = nn;
        m                = mm;
        lhs_zp           = zp;
        lhs_base         = base;
        lhs_row_stride_b = stride;
        plan_tiles(kk, nn, mm, base, stride);
        tiles     = tile_q.size();
        req_rises = 0;
        init_cfg  = 1'b1;
        next_cycle();
        init_cfg  = 1'b0;
        repeat (tiles) begin
            while (!load_ia_req) next_cycle();
            repeat ($urandom_range(0, 3)) next_cycle();
            load_ia_granted = 1'b1;
            next_cycle();
            load_ia_granted = 1'b0;
            send_ia_trigger = 1'b1;  // stray trigger in LOAD, no data yet
            next_cycle();
            send_ia_trigger = 1'b0;
            while (!ia_data_valid) next_cycle();
            repeat ($urandom_range(0, 3)) next_cycle();
            send_ia_trigger = 1'b1;
            next_cycle();
            send_ia_trigger = 1'b0;
            while (!ia_sending_done) next_cycle();
        end
        repeat (20) begin  // loader must stay quiet after its last tile
            next_cycle();
            assert (!load_ia_req) else abort_run("load_ia_req raised after the last tile");
        end
        assert (req_rises == tiles) else value_error("load_ia_req rises", req_rises, tiles);
        assert (tile_q.size() == 0) else value_error("tiles left unsent", tile_q.size(), 0);
        assert (cmd_addr_q.size() == 0) else value_error("rows never fetched", cmd_addr_q.size(), 0);
    endtask

    // ==================================================
    // scoreboard, sampled at the rising edge
    // ==================================================
    always @(posedge clk) begin
        tile_exp_t t;
        if (rst_n) begin
            if (icb_cmd_valid && icb_cmd_ready) begin
                if (cmd_addr_q.size() == 0) abort_run("command issued with no row left to fetch");
                assert (icb_cmd_addr == cmd_addr_q[0])
                    else value_error("icb_cmd_addr", icb_cmd_addr, cmd_addr_q[0]);
                assert (icb_cmd_len == cmd_len_q[0])
                    else value_error("icb_cmd_len", icb_cmd_len, cmd_len_q[0]);
                void'(cmd_addr_q.pop_front());
                void'(cmd_len_q.pop_front());
            end
            if (load_ia_req && !req_seen) req_rises++;
            if (grant_seen) begin
                assert (!load_ia_req) else abort_run("load_ia_req still high after the grant edge");
            end
            req_seen   = load_ia_req;
            grant_seen = load_ia_req && load_ia_granted;
            if (done_pending) begin  // cycle after the last row
                assert (ia_sending_done) else abort_run("ia_sending_done missing after the last row");
                assert (!ia_row_valid) else abort_run("row streamed past the tile's row count");
                void'(tile_q.pop_front());
                row_cnt      = 0;
                done_pending = 1'b0;
            end else if (ia_sending_done) begin
                abort_run("ia_sending_done pulsed before the tile finished streaming");
            end else if (ia_row_valid) begin
                if (tile_q.size() == 0) abort_run("row valid with no tile pending");
                t = tile_q[0];
                if (row_cnt == 0) begin
                    assert (send_ia_trigger && ia_data_valid)
                        else abort_run("row stream started without a trigger on valid data");
                end
                assert (ia_is_init_data == t.first)
                    else value_error("ia_is_init_data", ia_is_init_data, t.first);
                assert (ia_calc_done == t.last) else value_error("ia_calc_done", ia_calc_done, t.last);
                for (int c = 0; c < t.cols; c++) begin
                    assert (int'(ia_out[c]) == expect_elem(t.addr + row_cnt * int'(lhs_row_stride_b)
                                                          + c * (use_16bits ? 2 : 1)))
                        else value_error($sformatf("ia_out[%0d] row %0d", c, row_cnt), ia_out[c],
                                         expect_elem(t.addr + row_cnt * int'(lhs_row_stride_b)
                                                     + c * (use_16bits ? 2 : 1)));
                end
                row_cnt++;
                if (row_cnt == t.rows) done_pending = 1'b1;
            end else if (row_cnt != 0) begin
                abort_run($sformatf("row stream stopped after %0d rows", row_cnt));
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= timeout_cycles) abort_run($sformatf("timeout after %0d cycles", cycles));
    end

    initial begin
        void'($urandom(38855));
        rst_n            = 1'b0;
        init_cfg         = 1'b0;
        use_16bits       = 1'b0;
        load_ia_granted  = 1'b0;
        send_ia_trigger  = 1'b0;
        k                = '0;
        n                = '0;
        m                = '0;
        lhs_zp           = '0;
        lhs_row_stride_b = '0;
        lhs_base         = '0;
        repeat (3) @(posedge clk);
        #1;
        assert (!load_ia_req && !icb_cmd_valid && !icb_rsp_ready && !ia_data_valid &&
                !ia_row_valid && !ia_sending_done && !ia_is_init_data && !ia_calc_done)
            else abort_run("outputs not cleared during reset");
        rst_n = 1'b1;
        next_cycle();
        run_gemm(1'b0, 18, 20, 20, 5, 'h100, 64);       // s8, edge tiles both ways
        run_gemm(1'b1, 16, 8, 16, -32000, 'h400, 32);  // s16, zp drives saturation
        $display("TEST PASS");
        $finish;
    end

endmodule

// File: tests/ia_icb_mem.sv
// ICB read slave model for the loader testbench, fixed byte pattern with random stalls
`timescale 1ns/1ps

module ia_icb_mem (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        icb_cmd_valid,
    output logic        icb_cmd_ready,
    input  logic [31:0] icb_cmd_addr,
    input  logic [3:0]  icb_cmd_len,
    output logic        icb_rsp_valid,
    input  logic        icb_rsp_ready,
    output logic [31:0] icb_rsp_rdata
);

    logic [31:0] beat_addr_q [$];  // beats still owed, in command order

    // byte at address a is (a*7+3) mod 256
    function automatic logic [7:0] byte_at(logic [31:0] a);
        return 8'((a * 7 + 3) & 32'hff);
    endfunction

    // little endian packing, lowest address in bits 7:0
    function automatic logic [31:0] word_at(logic [31:0] a);
        return {byte_at(a + 3), byte_at(a + 2), byte_at(a + 1), byte_at(a)};
    endfunction

    initial begin
        icb_cmd_ready = 1'b0;
        icb_rsp_valid = 1'b0;
        icb_rsp_rdata = '0;
    end

    always @(posedge clk) begin
        if (!rst_n) begin
            beat_addr_q.delete();
        end else begin
            // handshakes seen with the values held before this edge
            if (icb_cmd_valid && icb_cmd_ready) begin
                for (int b = 0; b <= icb_cmd_len; b++) begin
                    beat_addr_q.push_back(icb_cmd_addr + 4 * b);
                end
            end
            if (icb_rsp_valid && icb_rsp_ready) begin
                void'(beat_addr_q.pop_front());
            end
        end
        #1;
        icb_cmd_ready = rst_n && ($urandom_range(0, 2) != 0);  // stall about 1 in 3
        if (rst_n && beat_addr_q.size() != 0 && $urandom_range(0, 3) != 0) begin
            icb_rsp_valid = 1'b1;
            icb_rsp_rdata = word_at(beat_addr_q[0]);
        end else begin
            icb_rsp_valid = 1'b0;  // response gap
        end
    end

endmodule

// File: rtl/ia_loader.sv
// input activation loader top, ties the sequencer, ICB read path, lanes and tile buffer together
`timescale 1ns/1ps
`include "ia_loader_cfg.svh"

module ia_loader (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      init_cfg,
    input  ia_loader_pkg::reg_word_t  k,
    input  ia_loader_pkg::reg_word_t  n,
    input  ia_loader_pkg::reg_word_t  m,
    input  ia_loader_pkg::reg_word_t  lhs_zp,
    input  ia_loader_pkg::reg_word_t  lhs_row_stride_b,
    input  ia_loader_pkg::reg_word_t  lhs_base,
    input  logic                      use_16bits,
    output logic                      load_ia_req,
    input  logic                      load_ia_granted,
    input  logic                      send_ia_trigger,
    // ICB read master
    output logic                      icb_cmd_valid,
    input  logic                      icb_cmd_ready,
    output ia_loader_pkg::addr_t      icb_cmd_addr,
    output ia_loader_pkg::burst_len_t icb_cmd_len,
    input  logic                      icb_rsp_valid,
    output logic                      icb_rsp_ready,
    input  ia_loader_pkg::bus_word_t  icb_rsp_rdata,
    // array side
    output logic                      ia_data_valid,
    output logic                      ia_row_valid,
    output logic                      ia_is_init_data,
    output logic                      ia_calc_done,
    output logic                      ia_sending_done,
    output ia_loader_pkg::elem_t      ia_out [`IA_SIZE]
);

    // sequencer state shared by the datapath
    ia_loader_pkg::addr_t      tile_addr;
    ia_loader_pkg::addr_t      row_stride;
    ia_loader_pkg::row_cnt_t   tile_rows;
    ia_loader_pkg::beat_cnt_t  row_beats;
    ia_loader_pkg::reg_word_t  zp_q;
    logic                      use_16bits_q;
    logic                      load_en;
    logic                      send_en;
    logic                      first_col_tile;
    logic                      last_col_loop;
    logic                      tile_loaded;

    // beat to lane to buffer
    logic                      beat_hs;
    ia_loader_pkg::row_idx_t   wr_row;
    ia_loader_pkg::row_idx_t   wr_col_base;
    logic [15:0]               lane_raw [`IA_LANES];
    logic [`IA_LANES-1:0]      lane_en;
    ia_loader_pkg::elem_t      lane_elem [`IA_LANES];

    ia_tile_sequencer u_seq (
        .*,
        .sending_done (ia_sending_done)
    );

    ia_read_requester u_req (.*);

    ia_beat_unpacker u_unpack (.*);

    for (genvar i = 0; i < `IA_LANES; i++) begin : gen_lane
        ia_lane_convert u_conv (
            .raw      (lane_raw[i]),
            .is_16bit (use_16bits_q),
            .zp       (zp_q),
            .elem     (lane_elem[i])
        );
    end

    ia_tile_buffer u_buf (.*);

endmodule

// File: rtl/ia_tile_buffer.sv
// holds one converted tile and streams it to the array one row per cycle on trigger
`timescale 1ns/1ps
`include "ia_loader_cfg.svh"

module ia_tile_buffer (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    beat_hs,
    input  ia_loader_pkg::row_idx_t wr_row,
    input  ia_loader_pkg::row_idx_t wr_col_base,
    input  logic [`IA_LANES-1:0]    lane_en,
    input  ia_loader_pkg::elem_t    lane_elem [`IA_LANES],
    input  logic                    send_en,
    input  logic                    tile_loaded,
    input  ia_loader_pkg::row_cnt_t tile_rows,
    input  logic                    first_col_tile,
    input  logic                    last_col_loop,
    input  logic                    send_ia_trigger,
    output logic                    ia_data_valid,
    output logic                    ia_row_valid,
    output logic                    ia_is_init_data,
    output logic                    ia_calc_done,
    output logic                    ia_sending_done,
    output ia_loader_pkg::elem_t    ia_out [`IA_SIZE]
);

    ia_loader_pkg::elem_t    mem [`IA_SIZE][`IA_SIZE];
    ia_loader_pkg::row_cnt_t send_row;  // next row to put out
    ia_loader_pkg::row_idx_t rd_row;
    logic start;
    logic busy;  // rows 1.. in flight

    // ==================================================
    // fill side
    // ==================================================
    always_ff @(posedge clk) begin
        if (beat_hs) begin
            for (int i = 0; i < `IA_LANES; i++) begin
                if (lane_en[i]) begin
                    mem[wr_row][wr_col_base + ia_loader_pkg::row_idx_t'(i)] <= lane_elem[i];
                end
            end
        end
    end

    assign start = send_ia_trigger && ia_data_valid;  // trigger without data ignored

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ia_data_valid <= 1'b0;
        end else if (tile_loaded) begin
            ia_data_valid <= 1'b1;
        end else if (start) begin
            ia_data_valid <= 1'b0;
        end
    end

    // ==================================================
    // send side
    // ==================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy            <= 1'b0;
            send_row        <= '0;
            ia_sending_done <= 1'b0;
        end else begin
            ia_sending_done <= 1'b0;
            if (start) begin  // row 0 goes out this cycle
                send_row        <= 5'd1;
                busy            <= (tile_rows > 5'd1);
                ia_sending_done <= (tile_rows == 5'd1);
            end else if (busy) begin
                send_row <= send_row + 1'b1;
                if (send_row == tile_rows - 1'b1) begin
                    busy            <= 1'b0;
                    ia_sending_done <= 1'b1;
                end
            end
        end
    end

    assign rd_row          = busy ? send_row[`IA_SIZE_LOG2-1:0] : '0;
    assign ia_row_valid    = start || busy;
    assign ia_is_init_data = ia_row_valid && first_col_tile;
    assign ia_calc_done    = ia_row_valid && last_col_loop;

    for (genvar c = 0; c < `IA_SIZE; c++) begin : gen_out
        assign ia_out[c] = mem[rd_row][c];
    end

    a_rows_in_send: assert property (@(posedge clk) disable iff (!rst_n)
        ia_row_valid |-> send_en);

endmodule

// File: rtl/ia_lane_convert.sv
// one lane: sign-extends a raw element and adds the zero point with 16-bit saturation
`timescale 1ns/1ps

module ia_lane_convert (
    input  logic [15:0]              raw,
    input  logic                     is_16bit,
    input  ia_loader_pkg::reg_word_t zp,
    output ia_loader_pkg::elem_t     elem
);

    logic [15:0]        ext;  // element as s16
    logic signed [32:0] sum;  // one spare bit, no wrap

    assign ext = is_16bit ? raw : {{8{raw[7]}}, raw[7:0]};
    assign sum = $signed({{17{ext[15]}}, ext}) + $signed({zp[31], zp});

    // clamp to s16
    assign elem = (sum > 33'sd32767)  ? 16'sh7fff :
                  (sum < -33'sd32768) ? 16'sh8000 : sum[15:0];

endmodule

// File: rtl/ia_beat_unpacker.sv
// takes ICB read beats, tracks row and beat position, splits beats into lanes
`timescale 1ns/1ps
`include "ia_loader_cfg.svh"

module ia_beat_unpacker (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     load_en,
    input  logic                     use_16bits_q,
    input  ia_loader_pkg::row_cnt_t  tile_rows,
    input  ia_loader_pkg::beat_cnt_t row_beats,
    input  logic                     icb_rsp_valid,
    input  ia_loader_pkg::bus_word_t icb_rsp_rdata,
    output logic                     icb_rsp_ready,
    output logic                     tile_loaded,
    output logic                     beat_hs,
    output ia_loader_pkg::row_idx_t  wr_row,
    output ia_loader_pkg::row_idx_t  wr_col_base,
    output logic [15:0]              lane_raw [`IA_LANES],
    output logic [`IA_LANES-1:0]     lane_en
);

    ia_loader_pkg::beat_cnt_t beat_cnt;
    logic [5:0] col_base;  // first column of this beat, wide for the edge check
    logic last_beat;
    logic last_row;

    assign icb_rsp_ready = load_en;  // never back-pressures in LOAD
    assign beat_hs       = icb_rsp_valid && icb_rsp_ready;
    assign last_beat     = (beat_cnt == row_beats - 1'b1);
    assign last_row      = (wr_row == tile_rows - 1'b1);
    assign tile_loaded   = beat_hs && last_beat && last_row;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            beat_cnt <= '0;
            wr_row   <= '0;
        end else if (!load_en) begin
            beat_cnt <= '0;
            wr_row   <= '0;
        end else if (beat_hs) begin
            if (last_beat) begin
                beat_cnt <= '0;
                wr_row   <= wr_row + 1'b1;
            end else begin
                beat_cnt <= beat_cnt + 1'b1;
            end
        end
    end

    // beat x2 for halfwords, x4 for bytes
    assign col_base    = use_16bits_q ? {1'b0, beat_cnt, 1'b0} : {beat_cnt, 2'b00};
    assign wr_col_base = col_base[`IA_SIZE_LOG2-1:0];

    for (genvar i = 0; i < `IA_LANES; i++) begin : gen_slice
        assign lane_raw[i] = use_16bits_q ? icb_rsp_rdata[16*(i%2) +: 16]
                                          : {8'h00, icb_rsp_rdata[8*i +: 8]};
        // s16 uses lanes 0/1 only, drop columns past the tile edge
        assign lane_en[i]  = beat_hs && (!use_16bits_q || i < 2) && (col_base + i < `IA_SIZE);
    end

endmodule

// File: rtl/ia_read_requester.sv
// issues one ICB read burst per valid row of the current tile
`timescale 1ns/1ps

module ia_read_requester (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      load_en,
    input  ia_loader_pkg::addr_t      tile_addr,
    input  ia_loader_pkg::addr_t      row_stride,
    input  ia_loader_pkg::row_cnt_t   tile_rows,
    input  ia_loader_pkg::beat_cnt_t  row_beats,
    input  logic                      icb_cmd_ready,
    output logic                      icb_cmd_valid,
    output ia_loader_pkg::addr_t      icb_cmd_addr,
    output ia_loader_pkg::burst_len_t icb_cmd_len
);

    ia_loader_pkg::row_cnt_t issued;  // rows already accepted
    ia_loader_pkg::addr_t    row_addr;
    logic cmd_hs;

    assign cmd_hs = icb_cmd_valid && icb_cmd_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            icb_cmd_valid <= 1'b0;
            issued        <= '0;
        end else if (!load_en) begin
            icb_cmd_valid <= 1'b0;
            issued        <= '0;
        end else if (cmd_hs) begin
            issued        <= issued + 1'b1;
            icb_cmd_valid <= (issued + 1 < tile_rows);  // back to back
        end else if (!icb_cmd_valid) begin
            icb_cmd_valid <= (issued < tile_rows);
        end
    end

    // row address walks by stride, reloaded outside LOAD
    always_ff @(posedge clk) begin
        if (!load_en) begin
            row_addr <= tile_addr;
        end else if (cmd_hs) begin
            row_addr <= row_addr + row_stride;
        end
    end

    assign icb_cmd_addr = row_addr;
    assign icb_cmd_len  = row_beats - 1'b1;  // row_beats constant through LOAD

    a_cmd_hold: assert property (@(posedge clk) disable iff (!rst_n)
        icb_cmd_valid && !icb_cmd_ready |=>
            icb_cmd_valid && $stable(icb_cmd_addr) && $stable(icb_cmd_len));

endmodule

// File: rtl/ia_tile_sequencer.sv
// latches the GEMM shape and walks bands, loop passes and column tiles for the loader
`timescale 1ns/1ps
`include "ia_loader_cfg.svh"

module ia_tile_sequencer (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     init_cfg,
    input  ia_loader_pkg::reg_word_t k,
    input  ia_loader_pkg::reg_word_t n,
    input  ia_loader_pkg::reg_word_t m,
    input  ia_loader_pkg::reg_word_t lhs_zp,
    input  ia_loader_pkg::reg_word_t lhs_row_stride_b,
    input  ia_loader_pkg::reg_word_t lhs_base,
    input  logic                     use_16bits,
    input  logic                     load_ia_granted,
    input  logic                     tile_loaded,
    input  logic                     sending_done,
    output logic                     load_ia_req,
    output logic                     load_en,
    output logic                     send_en,
    output ia_loader_pkg::addr_t     tile_addr,
    output ia_loader_pkg::addr_t     row_stride,
    output ia_loader_pkg::row_cnt_t  tile_rows,
    output ia_loader_pkg::beat_cnt_t row_beats,
    output logic                     use_16bits_q,
    output ia_loader_pkg::reg_word_t zp_q,
    output logic                     first_col_tile,
    output logic                     last_col_loop
);

    ia_loader_pkg::seq_state_t state;

    ia_loader_pkg::reg_word_t row_tile_num;  // ceil(n/SIZE), column tiles per band
    ia_loader_pkg::reg_word_t col_tile_num;  // ceil(k/SIZE), bands
    ia_loader_pkg::reg_word_t loop_num;      // ceil(m/SIZE), passes per band
    ia_loader_pkg::reg_word_t row_tile_rem;  // dead columns in last col tile
    ia_loader_pkg::reg_word_t col_tile_rem;  // dead rows in last band

    ia_loader_pkg::reg_word_t col_idx;
    ia_loader_pkg::reg_word_t loop_cnt;
    ia_loader_pkg::reg_word_t band_idx;
    ia_loader_pkg::addr_t     band_base;     // address of current band, col 0

    ia_loader_pkg::reg_word_t n_tiles;
    ia_loader_pkg::reg_word_t k_tiles;
    ia_loader_pkg::row_cnt_t  valid_cols;
    logic last_col;
    logic last_loop;
    logic last_band;

    // ==================================================
    // shape latch, ceil by add and shift
    // ==================================================
    assign n_tiles = (n + `IA_SIZE - 1) >> `IA_SIZE_LOG2;
    assign k_tiles = (k + `IA_SIZE - 1) >> `IA_SIZE_LOG2;

    always_ff @(posedge clk) begin
        if (state == ia_loader_pkg::IDLE && init_cfg) begin
            row_tile_num <= n_tiles;
            col_tile_num <= k_tiles;
            loop_num     <= (m + `IA_SIZE - 1) >> `IA_SIZE_LOG2;
            row_tile_rem <= (n_tiles << `IA_SIZE_LOG2) - n;
            col_tile_rem <= (k_tiles << `IA_SIZE_LOG2) - k;
            row_stride   <= lhs_row_stride_b;
            zp_q         <= lhs_zp;
            use_16bits_q <= use_16bits;
        end
    end

    assign last_col  = (col_idx == row_tile_num - 1);
    assign last_loop = (loop_cnt == loop_num - 1);
    assign last_band = (band_idx == col_tile_num - 1);

    // edge tiles shrink, rows past k are never fetched
    assign tile_rows  = last_band ? ia_loader_pkg::row_cnt_t'(`IA_SIZE - col_tile_rem)
                                  : ia_loader_pkg::row_cnt_t'(`IA_SIZE);
    assign valid_cols = last_col ? ia_loader_pkg::row_cnt_t'(`IA_SIZE - row_tile_rem)
                                 : ia_loader_pkg::row_cnt_t'(`IA_SIZE);
    // 2 halfwords or 4 bytes per beat
    assign row_beats  = use_16bits_q ? ia_loader_pkg::beat_cnt_t'((valid_cols + 1) >> 1)
                                     : ia_loader_pkg::beat_cnt_t'((valid_cols + 3) >> 2);

    // ==================================================
    // tile walk, running sums instead of multiplies
    // ==================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            col_idx   <= '0;
            loop_cnt  <= '0;
            band_idx  <= '0;
            band_base <= '0;
            tile_addr <= '0;
        end else if (state == ia_loader_pkg::IDLE && init_cfg) begin
            col_idx   <= '0;
            loop_cnt  <= '0;
            band_idx  <= '0;
            band_base <= lhs_base;
            tile_addr <= lhs_base;
        end else if (state == ia_loader_pkg::SEND && sending_done) begin
            if (!last_col) begin
                col_idx   <= col_idx + 1;
                tile_addr <= tile_addr + (ia_loader_pkg::addr_t'(`IA_SIZE) << use_16bits_q);
            end else if (!last_loop) begin  // replay same band
                col_idx   <= '0;
                loop_cnt  <= loop_cnt + 1;
                tile_addr <= band_base;
            end else begin  // next band, SIZE rows down
                col_idx   <= '0;
                loop_cnt  <= '0;
                band_idx  <= band_idx + 1;
                band_base <= band_base + (row_stride << `IA_SIZE_LOG2);
                tile_addr <= band_base + (row_stride << `IA_SIZE_LOG2);
            end
        end
    end

    // ==================================================
    // FSM and grant handshake
    // ==================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= ia_loader_pkg::IDLE;
            load_ia_req <= 1'b0;
        end else begin
            case (state)
                ia_loader_pkg::IDLE: if (init_cfg) state <= ia_loader_pkg::WAIT_GRANT;
                ia_loader_pkg::WAIT_GRANT: begin
                    if (load_ia_req && load_ia_granted) begin
                        state       <= ia_loader_pkg::LOAD;
                        load_ia_req <= 1'b0;  // drops on the grant edge
                    end else begin
                        load_ia_req <= 1'b1;
                    end
                end
                ia_loader_pkg::LOAD: if (tile_loaded) state <= ia_loader_pkg::SEND;
                ia_loader_pkg::SEND: begin
                    if (sending_done) begin
                        state <= (last_col && last_loop && last_band) ? ia_loader_pkg::IDLE
                                                                      : ia_loader_pkg::WAIT_GRANT;
                    end
                end
                default: state <= ia_loader_pkg::IDLE;
            endcase
        end
    end

    assign load_en        = (state == ia_loader_pkg::LOAD);
    assign send_en        = (state == ia_loader_pkg::SEND);
    assign first_col_tile = (col_idx == 0);  // accumulator clear
    assign last_col_loop  = last_col;        // final partial sum of this pass

    a_req_not_in_load: assert property (@(posedge clk) disable iff (!rst_n)
        load_en |-> !load_ia_req);
    a_done_in_send: assert property (@(posedge clk) disable iff (!rst_n)
        sending_done |-> send_en);

endmodule

// File: rtl/ia_loader_pkg.sv
// shared types for the activation loader, referenced by scoped name from every RTL block
`include "ia_loader_cfg.svh"

package ia_loader_pkg;

    typedef logic [`IA_REG_W-1:0]        reg_word_t;  // config register word
    typedef logic [`IA_REG_W-1:0]        addr_t;      // byte address
    typedef logic signed [`IA_DATA_W-1:0] elem_t;     // element after zp add
    typedef logic [`IA_BUS_W-1:0]        bus_word_t;  // one ICB beat

    typedef logic [`IA_SIZE_LOG2-1:0]    row_idx_t;   // row/col inside a tile
    typedef logic [`IA_SIZE_LOG2:0]      row_cnt_t;   // 1..SIZE
    typedef logic [3:0]                  beat_cnt_t;  // 1..8 beats per row
    typedef logic [3:0]                  burst_len_t; // ICB len, beats minus one

    // tile sequencer FSM
    typedef enum logic [1:0] {
        IDLE       = 2'd0,
        WAIT_GRANT = 2'd1,
        LOAD       = 2'd2,
        SEND       = 2'd3
    } seq_state_t;

endpackage

// File: include/ia_loader_cfg.svh
// sizing macros for the activation loader, included by the package, the RTL and the testbench
`ifndef IA_LOADER_CFG_SVH
`define IA_LOADER_CFG_SVH

// ==================================================
// array geometry
// ==================================================
`define IA_SIZE       16  // systolic array edge
`define IA_SIZE_LOG2  4   // shift for divide by edge

// ==================================================
// datapath and bus
// ==================================================
`define IA_DATA_W     16  // element width toward the array
`define IA_BUS_W      32  // ICB read data width
`define IA_REG_W      32  // config and address width
`define IA_LANES      (`IA_BUS_W / 8)  // s8 elements per beat

`endif
